//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_stream_dma
FILELIST  := tb.f
BUILD_DIR := obj_dir

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) dma_config.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)

//--- beat_fifo.sv
// Circular buffer for incoming stream beats
// Also counts the complete packets held so the writer only starts on whole packets

`default_nettype none

`include "dma_config.svh"

module beat_fifo (
    input  wire         clock,
    input  wire         reset,
    input  wire         in_valid,
    input  wire  [31:0] in_data,
    input  wire  [7:0]  in_dest,
    input  wire         in_last,
    output logic        in_ready,
    stream_if.fifo      out
);
    import dma_stream_pkg::*;

    localparam int DEPTH = `DMA_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int LEVEL_W = $clog2(DEPTH + 1);

    stream_beat_t mem [DEPTH];

    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [LEVEL_W-1:0] level;
    logic [LEVEL_W-1:0] level_next;
    logic [LEVEL_W-1:0] packets;
    logic [LEVEL_W-1:0] packets_next;
    logic               push;
    logic               pop;

    assign push = in_valid && in_ready;
    // A pop on an empty buffer is ignored
    assign pop = out.pop && (level != '0);

    always_comb begin
        level_next = level;
        if (push && !pop) begin
            level_next = level + 1'b1;
        end else if (pop && !push) begin
            level_next = level - 1'b1;
        end
    end

    // Packets are counted by their last beat on both sides
    always_comb begin
        packets_next = packets;
        if ((push && in_last) && !(pop && out.beat.last)) begin
            packets_next = packets + 1'b1;
        end else if (!(push && in_last) && (pop && out.beat.last)) begin
            packets_next = packets - 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level <= '0;
            packets <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            level <= level_next;
            packets <= packets_next;
            // Registered so the input never sees a full buffer as ready
            in_ready <= (level_next != LEVEL_W'(DEPTH));
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            mem[wr_ptr] <= '{data: in_data, dest: in_dest, last: in_last};
        end
    end

    assign out.beat = mem[rd_ptr];
    assign out.level = level;
    assign out.packet_ready = (packets != '0);

endmodule

`default_nettype wire

//--- dma_bus_pkg.sv
// Stream DMA bus and register types
// Write bus address and data words, register index and status layout

`default_nettype none

`include "dma_config.svh"

package dma_bus_pkg;

    typedef logic [`DMA_ADDR_WIDTH-1:0] bus_addr_t;

    typedef logic [63:0] bus_data_t;

    // Index into the four-entry register map
    typedef logic [1:0] reg_addr_t;

    // Status register, packet count in the upper half
    typedef struct packed {
        logic [15:0] packets_done;
        logic [15:0] last_length;
    } dma_status_t;

endpackage

`default_nettype wire

//--- dma_config.svh
// Build-time configuration of the stream DMA writer
// Beat buffer depth, bus address width and register map offsets

`ifndef DMA_CONFIG_SVH
`define DMA_CONFIG_SVH

// Beats held by the input FIFO, which is also the longest packet accepted
`define DMA_FIFO_DEPTH 16

// Width of the memory bus address
`define DMA_ADDR_WIDTH 64

// Register map, one 32-bit register per index
`define DMA_REG_CTRL    2'd0
`define DMA_REG_BASE_LO 2'd1
`define DMA_REG_BASE_HI 2'd2
`define DMA_REG_STATUS  2'd3

`endif

//--- dma_regs.sv
// Configuration registers of the stream DMA writer
// Holds enable and base address, counts finished packets and keeps the last length

`default_nettype none

`include "dma_config.svh"

module dma_regs (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        cfg_write,
    input  wire dma_bus_pkg::reg_addr_t cfg_addr,
    input  wire  [31:0]                cfg_wdata,
    input  wire                        finish,
    input  wire  [15:0]                finish_length,
    output logic [31:0]                cfg_rdata,
    output logic                       enable,
    output dma_bus_pkg::bus_addr_t     base_addr
);
    import dma_bus_pkg::*;

    dma_status_t status;

    always_ff @(posedge clock) begin
        if (!reset) begin
            enable <= 1'b0;
            base_addr <= '0;
            status <= '0;
        end else begin
            if (cfg_write) begin
                case (cfg_addr)
                    `DMA_REG_CTRL: begin
                        enable <= cfg_wdata[0];
                    end
                    `DMA_REG_BASE_LO: begin
                        base_addr[31:0] <= cfg_wdata;
                    end
                    `DMA_REG_BASE_HI: begin
                        base_addr[`DMA_ADDR_WIDTH-1:32] <= cfg_wdata;
                    end
                    // Status is read-only
                    default: begin
                    end
                endcase
            end
            if (finish) begin
                // The packet counter wraps at 16 bits
                status.packets_done <= status.packets_done + 16'd1;
                status.last_length <= finish_length;
            end
        end
    end

    always_comb begin
        case (cfg_addr)
            `DMA_REG_CTRL: begin
                cfg_rdata = {31'd0, enable};
            end
            `DMA_REG_BASE_LO: begin
                cfg_rdata = base_addr[31:0];
            end
            `DMA_REG_BASE_HI: begin
                cfg_rdata = base_addr[`DMA_ADDR_WIDTH-1:32];
            end
            default: begin
                cfg_rdata = status;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- dma_stream_pkg.sv
// Stream DMA data types
// Input beat layout and the 64-bit memory word written per beat

`default_nettype none

package dma_stream_pkg;

    // One buffered beat of the input stream
    typedef struct packed {
        logic [31:0] data;
        logic [7:0]  dest;
        logic        last;
    } stream_beat_t;

    // Memory word as the writer builds it, tag zero-extended into the high half
    typedef struct packed {
        logic [23:0] pad;
        logic [7:0]  dest;
        logic [31:0] data;
    } mem_word_fields_t;

    // The bus only sees the raw view
    typedef union packed {
        logic [63:0]      raw;
        mem_word_fields_t fields;
    } mem_word_t;

endpackage

`default_nettype wire

//--- dma_writer.sv
// DMA write engine
// Pops queued beats and issues one single-word bus write per beat at base + 8 * index

`default_nettype none

module dma_writer (
    input  wire                    clock,
    input  wire                    reset,
    input  wire                    enable,
    input  wire dma_bus_pkg::bus_addr_t base_addr,
    input  wire                    aw_ready,
    input  wire                    w_ready,
    input  wire                    b_valid,
    stream_if.writer               in,
    output logic                   aw_valid,
    output dma_bus_pkg::bus_addr_t aw_addr,
    output logic                   w_valid,
    output dma_bus_pkg::bus_data_t w_data,
    output logic                   b_ready,
    output logic                   finish,
    output logic [15:0]            finish_length,
    output logic                   done
);
    import dma_stream_pkg::*;
    import dma_bus_pkg::*;

    typedef enum logic [1:0] {
        writer_idle,
        writer_load,
        writer_send,
        writer_response
    } writer_state_t;

    writer_state_t state;

    logic [15:0] word_index;
    bus_addr_t   target_base;
    bus_addr_t   next_base;
    mem_word_t   word;
    logic        beat_last;
    logic        start;
    logic        take_beat;
    logic        aw_clear;
    logic        w_clear;
    logic        b_fire;

    // The first beat is taken straight from idle so the write starts a cycle later
    assign start = (state == writer_idle) && in.packet_ready && enable;
    assign take_beat = start || ((state == writer_load) && (in.level != '0));
    assign in.pop = take_beat;

    // Base is latched at packet start, later changes only affect the next packet
    assign next_base = start ? base_addr : target_base;

    // A channel counts as finished once its valid has dropped or is accepted now
    assign aw_clear = aw_ready || !aw_valid;
    assign w_clear = w_ready || !w_valid;

    assign b_fire = (state == writer_response) && b_valid && b_ready;

    // The register block latches the status on the same edge that raises done
    assign finish = b_fire && beat_last;
    assign finish_length = word_index + 16'd1;

    assign w_data = word.raw;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= writer_idle;
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            b_ready <= 1'b1;
            done <= 1'b0;
            word_index <= '0;
        end else begin
            done <= 1'b0;
            b_ready <= 1'b1;
            case (state)
                writer_idle, writer_load: begin
                    if (take_beat) begin
                        aw_valid <= 1'b1;
                        w_valid <= 1'b1;
                        state <= writer_send;
                    end
                end
                writer_send: begin
                    if (aw_ready) begin
                        aw_valid <= 1'b0;
                    end
                    if (w_ready) begin
                        w_valid <= 1'b0;
                    end
                    if (aw_clear && w_clear) begin
                        state <= writer_response;
                    end
                end
                writer_response: begin
                    if (b_fire) begin
                        // Ready drops for the cycle after a response
                        b_ready <= 1'b0;
                        if (beat_last) begin
                            word_index <= '0;
                            done <= 1'b1;
                            state <= writer_idle;
                        end else begin
                            word_index <= word_index + 16'd1;
                            state <= writer_load;
                        end
                    end
                end
                default: begin
                    state <= writer_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (start) begin
            target_base <= base_addr;
        end
        if (take_beat) begin
            aw_addr <= next_base + (bus_addr_t'(word_index) << 3);
            word.fields <= '{pad: '0, dest: in.beat.dest, data: in.beat.data};
            beat_last <= in.beat.last;
        end
    end

endmodule

`default_nettype wire

//--- stream_dma.sv
// Stream-to-memory DMA writer top level
// Beat FIFO, register block and write engine behind plain stream, bus and config ports

`default_nettype none

`include "dma_config.svh"

module stream_dma (
    input  wire                        clock,
    input  wire                        reset,
    input  wire                        in_valid,
    output logic                       in_ready,
    input  wire  [31:0]                in_data,
    input  wire  [7:0]                 in_dest,
    input  wire                        in_last,
    output logic                       aw_valid,
    input  wire                        aw_ready,
    output logic [`DMA_ADDR_WIDTH-1:0] aw_addr,
    output logic                       w_valid,
    input  wire                        w_ready,
    output logic [63:0]                w_data,
    input  wire                        b_valid,
    output logic                       b_ready,
    input  wire                        cfg_write,
    input  wire  [1:0]                 cfg_addr,
    input  wire  [31:0]                cfg_wdata,
    output logic [31:0]                cfg_rdata,
    output logic                       done
);

    logic                       enable;
    logic [`DMA_ADDR_WIDTH-1:0] base_addr;
    logic                       finish;
    logic [15:0]                finish_length;

    stream_if #(.DEPTH(`DMA_FIFO_DEPTH)) u_stream_if ();

    beat_fifo u_beat_fifo (
        .clock    (clock),
        .reset    (reset),
        .in_valid (in_valid),
        .in_data  (in_data),
        .in_dest  (in_dest),
        .in_last  (in_last),
        .in_ready (in_ready),
        .out      (u_stream_if.fifo)
    );

    dma_regs u_dma_regs (
        .clock         (clock),
        .reset         (reset),
        .cfg_write     (cfg_write),
        .cfg_addr      (cfg_addr),
        .cfg_wdata     (cfg_wdata),
        .finish        (finish),
        .finish_length (finish_length),
        .cfg_rdata     (cfg_rdata),
        .enable        (enable),
        .base_addr     (base_addr)
    );

    dma_writer u_dma_writer (
        .clock         (clock),
        .reset         (reset),
        .enable        (enable),
        .base_addr     (base_addr),
        .aw_ready      (aw_ready),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .in            (u_stream_if.writer),
        .aw_valid      (aw_valid),
        .aw_addr       (aw_addr),
        .w_valid       (w_valid),
        .w_data        (w_data),
        .b_ready       (b_ready),
        .finish        (finish),
        .finish_length (finish_length),
        .done          (done)
    );

endmodule

`default_nettype wire

//--- stream_if.sv
// Buffered beat channel between the beat FIFO and the DMA writer

`default_nettype none

`include "dma_config.svh"

interface stream_if #(
    parameter int DEPTH = `DMA_FIFO_DEPTH
);
    import dma_stream_pkg::*;

    // Head of the FIFO, valid whenever level is non-zero
    stream_beat_t beat;
    logic pop;
    // High while at least one complete packet is queued
    logic packet_ready;
    logic [$clog2(DEPTH + 1)-1:0] level;

    modport fifo (output beat, output packet_ready, output level, input pop);

    modport writer (input beat, input packet_ready, input level, output pop);

endinterface

`default_nettype wire

//--- tb.f
+incdir+.
dma_stream_pkg.sv
dma_bus_pkg.sv
stream_if.sv
beat_fifo.sv
dma_regs.sv
dma_writer.sv
stream_dma.sv
tb_stream_dma.sv

//--- tb_stream_dma.sv
// Directed testbench for the stream DMA writer
// Drives packets and registers, models the memory bus and checks every word written

`default_nettype none

`include "dma_config.svh"

module tb_stream_dma;

    localparam int TIMEOUT = 2000;

    logic                       clock;
    logic                       reset;
    logic                       in_valid;
    logic                       in_ready;
    logic [31:0]                in_data;
    logic [7:0]                 in_dest;
    logic                       in_last;
    logic                       aw_valid;
    logic                       aw_ready = 1'b0;
    logic [`DMA_ADDR_WIDTH-1:0] aw_addr;
    logic                       w_valid;
    logic                       w_ready = 1'b0;
    logic [63:0]                w_data;
    logic                       b_valid = 1'b0;
    logic                       b_ready;
    logic                       cfg_write;
    logic [1:0]                 cfg_addr;
    logic [31:0]                cfg_wdata;
    logic [31:0]                cfg_rdata;
    logic                       done;

    // Memory slave state
    logic        aw_seen = 1'b0;
    logic        w_seen = 1'b0;
    logic        b_pending = 1'b0;
    logic        b_taken = 1'b0;
    logic        slow_bus = 1'b0;
    int          b_wait = 0;
    logic [63:0] pend_addr = '0;
    logic [63:0] pend_data = '0;
    logic [63:0] mem_model [logic [63:0]];
    logic [63:0] log_addr [$];
    logic [63:0] log_data [$];
    int          done_count = 0;

    // Stimulus side bookkeeping
    logic        random_delays;
    logic [63:0] exp_addr [$];
    logic [63:0] exp_data [$];
    logic [63:0] base;
    int          log_next;
    int          packets_sent;
    int          last_sent_length;
    logic        stall_seen;

    stream_dma u_stream_dma (.*);

    always #5 clock = ~clock;

    always @(posedge clock) begin
        if (reset && done) begin
            done_count++;
        end
    end

    // The bus slave records each write once both address and data were accepted
    always @(posedge clock) begin
        if (reset) begin
            slow_bus = random_delays;
            b_taken = b_valid && b_ready;
            if (b_taken) begin
                b_pending = 1'b0;
            end
            if (aw_valid && aw_ready) begin
                aw_seen = 1'b1;
                pend_addr = aw_addr;
            end
            if (w_valid && w_ready) begin
                w_seen = 1'b1;
                pend_data = w_data;
            end
            if (aw_seen && w_seen) begin
                mem_model[pend_addr] = pend_data;
                log_addr.push_back(pend_addr);
                log_data.push_back(pend_data);
                aw_seen = 1'b0;
                w_seen = 1'b0;
                b_pending = 1'b1;
                b_wait = slow_bus ? int'($urandom_range(0, 4)) : 0;
            end
            #1;
            aw_ready = slow_bus ? ($urandom_range(0, 1) != 0) : 1'b1;
            w_ready = slow_bus ? ($urandom_range(0, 1) != 0) : 1'b1;
            if (b_taken) begin
                b_valid = 1'b0;
            end else if (b_pending && !b_valid) begin
                if (b_wait == 0) begin
                    b_valid = 1'b1;
                end else begin
                    b_wait--;
                end
            end
        end
    end

    task automatic check_value(input string test_name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", test_name, expected, actual);
            $display("sim failed");
            $fatal(1, "Value mismatch in %s", test_name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        $display("sim failed");
        $fatal(1, "Timeout");
    endtask

    task automatic idle_cycles(input int count);
        repeat (count) begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic reg_write(input logic [1:0] addr, input logic [31:0] value);
        cfg_write = 1'b1;
        cfg_addr = addr;
        cfg_wdata = value;
        @(posedge clock);
        #1;
        cfg_write = 1'b0;
    endtask

    // Read data is combinational and is taken mid-cycle
    task automatic reg_read(input logic [1:0] addr, output logic [31:0] value);
        cfg_addr = addr;
        @(negedge clock);
        value = cfg_rdata;
        @(posedge clock);
        #1;
    endtask

    // Each beat queues an expected word with the data low and the zero-extended dest high
    task automatic send_packet(input int length, input logic [7:0] dest,
                               input logic [31:0] first_word);
        int          cycles;
        logic [31:0] data;
        for (int k = 0; k < length; k++) begin
            data = first_word + 32'(k);
            in_valid = 1'b1;
            in_data = data;
            in_dest = dest;
            in_last = (k == length - 1);
            exp_addr.push_back(base + 64'(k) * 64'd8);
            exp_data.push_back({24'd0, dest, data});
            cycles = 0;
            @(posedge clock);
            while (!in_ready) begin
                stall_seen = 1'b1;
                cycles++;
                if (cycles > TIMEOUT) begin
                    report_timeout("in_ready");
                end
                @(posedge clock);
            end
            #1;
        end
        in_valid = 1'b0;
        in_last = 1'b0;
        packets_sent++;
        last_sent_length = length;
    endtask

    task automatic wait_packets(input int target);
        int cycles;
        cycles = 0;
        while (done_count < target) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                report_timeout("the done pulse");
            end
            @(posedge clock);
            #1;
        end
    endtask

    task automatic compare_write_log(input string test_name);
        check_value({test_name, " write count"}, 64'(log_next + exp_addr.size()),
                    64'(log_addr.size()));
        while (exp_addr.size() > 0) begin
            check_value({test_name, " address"}, exp_addr.pop_front(), log_addr[log_next]);
            check_value({test_name, " data"}, exp_data.pop_front(), log_data[log_next]);
            log_next++;
        end
    endtask

    task automatic register_access();
        logic [31:0] value;
        reg_read(`DMA_REG_STATUS, value);
        check_value("registers status", 64'd0, 64'(value));
        reg_write(`DMA_REG_BASE_LO, 32'h0000_2000);
        reg_write(`DMA_REG_BASE_HI, 32'h0000_0001);
        base = 64'h0000_0001_0000_2000;
        reg_read(`DMA_REG_BASE_LO, value);
        check_value("registers base_lo", 64'h0000_2000, 64'(value));
        reg_read(`DMA_REG_BASE_HI, value);
        check_value("registers base_hi", 64'h0000_0001, 64'(value));
        reg_write(`DMA_REG_CTRL, 32'h1);
        reg_read(`DMA_REG_CTRL, value);
        check_value("registers ctrl on", 64'd1, 64'(value));
        reg_write(`DMA_REG_CTRL, 32'h0);
        reg_read(`DMA_REG_CTRL, value);
        check_value("registers ctrl off", 64'd0, 64'(value));
    endtask

    task automatic single_packet();
        int start_count;
        start_count = done_count;
        reg_write(`DMA_REG_CTRL, 32'h1);
        send_packet(5, 8'ha5, 32'hc0de_0000);
        wait_packets(start_count + 1);
        // Extra cycles catch a second done pulse
        idle_cycles(20);
        check_value("single_packet done", 64'(start_count + 1), 64'(done_count));
        for (int k = 0; k < 5; k++) begin
            check_value("single_packet memory", {24'd0, 8'ha5, 32'hc0de_0000 + 32'(k)},
                        mem_model[base + 64'(k) * 64'd8]);
        end
        compare_write_log("single_packet");
    endtask

    task automatic status_count();
        logic [31:0] value;
        send_packet(2, 8'h11, 32'h0100_0000);
        send_packet(7, 8'h22, 32'h0200_0000);
        send_packet(3, 8'h33, 32'h0300_0000);
        wait_packets(packets_sent);
        compare_write_log("status");
        reg_read(`DMA_REG_STATUS, value);
        check_value("status packets_done", 64'(packets_sent), 64'(value[31:16]));
        check_value("status last_length", 64'(last_sent_length), 64'(value[15:0]));
    endtask

    task automatic enable_gating();
        int start_count;
        reg_write(`DMA_REG_CTRL, 32'h0);
        start_count = done_count;
        send_packet(4, 8'h3c, 32'h1234_0000);
        idle_cycles(50);
        check_value("enable_gating idle writes", 64'(log_next), 64'(log_addr.size()));
        check_value("enable_gating idle done", 64'(start_count), 64'(done_count));
        reg_write(`DMA_REG_CTRL, 32'h1);
        wait_packets(packets_sent);
        compare_write_log("enable_gating");
    endtask

    task automatic back_pressure();
        int length;
        int beats;
        int p;
        reg_write(`DMA_REG_BASE_LO, 32'h8000_0000);
        reg_write(`DMA_REG_BASE_HI, 32'h0000_0000);
        base = 64'h0000_0000_8000_0000;
        random_delays = 1'b1;
        stall_seen = 1'b0;
        beats = 0;
        p = 0;
        // Enough packets to fill the FIFO twice over
        while (p < 8 || beats <= 2 * `DMA_FIFO_DEPTH) begin
            length = int'($urandom_range(4, 10));
            send_packet(length, 8'(p + 64), {8'(p), 24'h0});
            beats += length;
            p++;
        end
        wait_packets(packets_sent);
        compare_write_log("back_pressure");
        check_value("back_pressure stall", 64'd1, 64'(stall_seen));
        random_delays = 1'b0;
    endtask

    initial begin
        void'($urandom(31161));
        clock = 1'b0;
        reset = 1'b0;
        in_valid = 1'b0;
        in_data = '0;
        in_dest = '0;
        in_last = 1'b0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        random_delays = 1'b0;
        base = '0;
        log_next = 0;
        packets_sent = 0;
        last_sent_length = 0;
        stall_seen = 1'b0;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b1;
        register_access();
        single_packet();
        status_count();
        enable_gating();
        back_pressure();
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
